// ==== hw/eeprom_pkg.sv ====
package eeprom_pkg;

    // bus timing, one SCL period is four quarters
    localparam int CLKS_PER_QUARTER = 4;

    localparam int ADDR_W = 11;   // 2 KB device
    localparam int DATA_W = 8;

    // control byte prefix for serial EEPROMs
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // bit engine commands, OP_START doubles as repeated start
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bit_op_t;

    // transaction sequencer states
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_RESP
    } seq_state_t;

endpackage

// ==== hw/i2c_byte_if.sv ====
`timescale 1ns/1ps

interface i2c_byte_if;

    logic                          cmd_valid;
    logic                          cmd_ready;
    eeprom_pkg::bit_op_t           cmd_op;
    logic [eeprom_pkg::DATA_W-1:0] cmd_wdata;
    logic                          cmd_mack;   // 1 = nack after a read
    logic                          done;       // one cycle at command end
    logic [eeprom_pkg::DATA_W-1:0] rdata;
    logic                          ack_in;     // slave ack bit, 0 = ack

    modport seq (
        output cmd_valid, cmd_op, cmd_wdata, cmd_mack,
        input  cmd_ready, done, rdata, ack_in
    );

    modport engine (
        input  cmd_valid, cmd_op, cmd_wdata, cmd_mack,
        output cmd_ready, done, rdata, ack_in
    );

endinterface

// ==== hw/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       sda_in,
    output logic       scl,
    output logic       sda_pull,
    i2c_byte_if.engine bus
);

    logic                                          busy;
    logic                                          done_q;
    logic                                          ack_q;
    logic [$clog2(eeprom_pkg::CLKS_PER_QUARTER)-1:0] qcnt;
    logic [1:0]                                    quarter;
    logic [3:0]                                    bitcnt;
    logic [3:0]                                    last_bit;
    logic                                          quarter_end;
    logic                                          pull_q1;

    eeprom_pkg::bit_op_t                           op_q;
    logic [eeprom_pkg::DATA_W-1:0]                 shreg;
    logic                                          mack_q;

    assign quarter_end = (32'(qcnt) == eeprom_pkg::CLKS_PER_QUARTER - 1);

    // start and stop are a single SCL period, bytes take nine
    assign last_bit = (op_q == eeprom_pkg::OP_START || op_q == eeprom_pkg::OP_STOP) ?
                      4'd0 : 4'd8;

    // scl low in quarters 0 and 1, bus idles high
    assign scl = !busy || quarter[1];

    assign bus.cmd_ready = !busy;
    assign bus.done      = done_q;
    assign bus.rdata     = shreg;
    assign bus.ack_in    = ack_q;

    // sda level set at the start of quarter 1
    always_comb
    begin
        case (op_q)
            eeprom_pkg::OP_START:
            begin
                pull_q1 = 1'b0;               // release while scl low
            end
            eeprom_pkg::OP_STOP:
            begin
                pull_q1 = 1'b1;
            end
            eeprom_pkg::OP_WRITE:
            begin
                if (bitcnt == 4'd8)
                    pull_q1 = 1'b0;           // let the slave ack
                else
                    pull_q1 = ~shreg[7];
            end
            default:
            begin
                if (bitcnt == 4'd8)
                    pull_q1 = ~mack_q;
                else
                    pull_q1 = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            done_q   <= 1'b0;
            sda_pull <= 1'b0;
            qcnt     <= '0;
            quarter  <= 2'd0;
            bitcnt   <= 4'd0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!busy)
            begin
                if (bus.cmd_valid)
                begin
                    busy    <= 1'b1;
                    qcnt    <= '0;
                    quarter <= 2'd0;
                    bitcnt  <= 4'd0;
                end
            end
            else if (quarter_end)
            begin
                qcnt    <= '0;
                quarter <= quarter + 2'd1;
                if (quarter == 2'd0)
                    sda_pull <= pull_q1;
                // start and stop edges fall in the scl high half
                if (quarter == 2'd2 && last_bit == 4'd0)
                    sda_pull <= (op_q == eeprom_pkg::OP_START);
                if (quarter == 2'd3)
                begin
                    if (bitcnt == last_bit)
                    begin
                        busy   <= 1'b0;
                        done_q <= 1'b1;
                    end
                    else
                    begin
                        bitcnt <= bitcnt + 4'd1;
                    end
                end
            end
            else
            begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    // command latch and shifter, sampled at the end of quarter 2
    always_ff @(posedge CLK)
    begin
        if (!busy && bus.cmd_valid)
        begin
            op_q   <= bus.cmd_op;
            shreg  <= bus.cmd_wdata;
            mack_q <= bus.cmd_mack;
        end
        else if (busy && quarter_end && quarter == 2'd2)
        begin
            if (bitcnt == 4'd8)
                ack_q <= sda_in;
            else if (last_bit == 4'd8)
                shreg <= {shreg[eeprom_pkg::DATA_W-2:0], sda_in}; // msb first
        end
    end

endmodule

// ==== hw/eeprom_sequencer.sv ====
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] req_wdata,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output logic [eeprom_pkg::DATA_W-1:0] rsp_rdata,
    output logic                          rsp_nack,
    i2c_byte_if.seq                       bus
);

    eeprom_pkg::seq_state_t        state;
    eeprom_pkg::seq_state_t        state_next;
    eeprom_pkg::bit_op_t           op;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    logic                          cmd_valid_q;
    logic                          nack;
    logic                          nack_hit;
    logic                          accept;

    logic                          wr_q;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0] wdata_q;
    logic [eeprom_pkg::DATA_W-1:0] rdata_q;

    assign accept    = req_valid && (state == eeprom_pkg::S_IDLE);
    assign req_ready = (state == eeprom_pkg::S_IDLE);
    assign rsp_valid = (state == eeprom_pkg::S_RESP);
    assign rsp_rdata = rdata_q;
    assign rsp_nack  = nack;

    // slave left the ack bit high after one of our bytes
    assign nack_hit  = bus.done && bus.ack_in && (op == eeprom_pkg::OP_WRITE);

    assign bus.cmd_valid = cmd_valid_q;
    assign bus.cmd_op    = op;
    assign bus.cmd_wdata = wdata;
    assign bus.cmd_mack  = 1'b1;      // single byte read always ends in nack

    // command for the current state
    always_comb
    begin
        op    = eeprom_pkg::OP_WRITE;
        wdata = '0;
        case (state)
            eeprom_pkg::S_START, eeprom_pkg::S_RESTART:
            begin
                op = eeprom_pkg::OP_START;
            end
            eeprom_pkg::S_CTRL_W:
            begin
                wdata = {eeprom_pkg::DEVICE_CODE, addr_q[eeprom_pkg::ADDR_W-1:8], 1'b0};
            end
            eeprom_pkg::S_ADDR:
            begin
                wdata = addr_q[7:0];
            end
            eeprom_pkg::S_DATA_W:
            begin
                wdata = wdata_q;
            end
            eeprom_pkg::S_CTRL_R:
            begin
                wdata = {eeprom_pkg::DEVICE_CODE, addr_q[eeprom_pkg::ADDR_W-1:8], 1'b1};
            end
            eeprom_pkg::S_DATA_R:
            begin
                op = eeprom_pkg::OP_READ;
            end
            eeprom_pkg::S_STOP:
            begin
                op = eeprom_pkg::OP_STOP;
            end
            default:
            begin
                op = eeprom_pkg::OP_WRITE;
            end
        endcase
    end

    always_comb
    begin
        state_next = state;
        case (state)
            eeprom_pkg::S_IDLE:
            begin
                if (req_valid)
                    state_next = eeprom_pkg::S_START;
            end
            eeprom_pkg::S_START:
            begin
                if (bus.done)
                    state_next = eeprom_pkg::S_CTRL_W;
            end
            eeprom_pkg::S_CTRL_W:
            begin
                if (bus.done)
                    state_next = nack_hit ? eeprom_pkg::S_STOP : eeprom_pkg::S_ADDR;
            end
            eeprom_pkg::S_ADDR:
            begin
                if (nack_hit || (bus.done && wr_q))
                    state_next = nack_hit ? eeprom_pkg::S_STOP : eeprom_pkg::S_DATA_W;
                else if (bus.done)
                    state_next = eeprom_pkg::S_RESTART;
            end
            eeprom_pkg::S_DATA_W:
            begin
                if (bus.done)
                    state_next = eeprom_pkg::S_STOP;
            end
            eeprom_pkg::S_RESTART:
            begin
                if (bus.done)
                    state_next = eeprom_pkg::S_CTRL_R;
            end
            eeprom_pkg::S_CTRL_R:
            begin
                if (bus.done)
                    state_next = nack_hit ? eeprom_pkg::S_STOP : eeprom_pkg::S_DATA_R;
            end
            eeprom_pkg::S_DATA_R:
            begin
                if (bus.done)
                    state_next = eeprom_pkg::S_STOP;
            end
            eeprom_pkg::S_STOP:
            begin
                if (bus.done)
                    state_next = eeprom_pkg::S_RESP;
            end
            default:
            begin
                state_next = eeprom_pkg::S_IDLE;   // S_RESP lasts one cycle
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= eeprom_pkg::S_IDLE;
            cmd_valid_q <= 1'b0;
            nack        <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (bus.cmd_valid && bus.cmd_ready)
                cmd_valid_q <= 1'b0;
            else if (state_next != state && state_next != eeprom_pkg::S_RESP &&
                     state_next != eeprom_pkg::S_IDLE)
                cmd_valid_q <= 1'b1;           // every other state issues a command
            if (accept)
                nack <= 1'b0;
            else if (nack_hit)
                nack <= 1'b1;
        end
    end

    // request and read data capture
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            wr_q    <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (state == eeprom_pkg::S_DATA_R && bus.done)
            rdata_q <= bus.rdata;
    end

endmodule

// ==== hw/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] req_wdata,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output logic [eeprom_pkg::DATA_W-1:0] rsp_rdata,
    output logic                          rsp_nack,
    output logic                          scl,
    output logic                          sda_pull,   // high pulls sda low
    input  logic                          sda_in
);

    i2c_byte_if u_byte_if ();

    eeprom_sequencer u_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .bus       (u_byte_if.seq)
    );

    i2c_bit_engine u_bit_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .sda_in   (sda_in),
        .scl      (scl),
        .sda_pull (sda_pull),
        .bus      (u_byte_if.engine)
    );

endmodule

// ==== tests/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_next,     // withhold the address byte ack
    output logic sda_pull,
    output logic bus_error
);

    logic [eeprom_pkg::DATA_W-1:0] mem [0:2047];
    logic                          scl_q;
    logic                          sda_q;
    logic                          active;
    logic                          tx;
    logic                          tx_next;
    logic                          wr_pending;
    logic [3:0]                    cnt;
    logic [1:0]                    byte_idx;
    logic [eeprom_pkg::DATA_W-1:0] shreg;
    logic [eeprom_pkg::DATA_W-1:0] txbyte;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic                          rise;
    logic                          fall;
    logic                          start_c;
    logic                          stop_c;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 7) ^ 8'(i >> 8);
    end

    assign rise    = scl && !scl_q;
    assign fall    = !scl && scl_q;
    assign start_c = scl && scl_q && sda_q && !sda;
    assign stop_c  = scl && scl_q && !sda_q && sda;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q <= 1'b1; sda_q <= 1'b1;
            active <= 1'b0; tx <= 1'b0; tx_next <= 1'b0; wr_pending <= 1'b0;
            cnt <= 4'd0; byte_idx <= 2'd0; sda_pull <= 1'b0; bus_error <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_c)
            begin
                // repeated start only right after the address byte
                if (active && !(byte_idx == 2'd2 && cnt <= 4'd1 && !wr_pending))
                    bus_error <= 1'b1;
                active <= 1'b1; cnt <= 4'd0; byte_idx <= 2'd0;
                tx <= 1'b0; tx_next <= 1'b0; wr_pending <= 1'b0; sda_pull <= 1'b0;
            end
            else if (stop_c)
            begin
                if (!active || cnt > 4'd1)
                    bus_error <= 1'b1;   // stray stop or sda glitch mid byte
                if (wr_pending)
                    mem[addr] <= wdata;
                active <= 1'b0; wr_pending <= 1'b0; tx <= 1'b0; sda_pull <= 1'b0;
            end
            else if (active && rise)
            begin
                if (cnt < 4'd8 && !tx)
                    shreg <= {shreg[6:0], sda};
                cnt <= cnt + 4'd1;
            end
            else if (active && fall)
            begin
                if (cnt == 4'd8)
                begin
                    if (tx)
                        sda_pull <= 1'b0;        // master acks the data
                    else
                    begin
                        case (byte_idx)
                            2'd0:
                            begin
                                if (shreg[7:4] == eeprom_pkg::DEVICE_CODE)
                                begin
                                    sda_pull   <= 1'b1;
                                    addr[10:8] <= shreg[3:1];
                                    tx_next    <= shreg[0];
                                end
                            end
                            2'd1:
                            begin
                                if (!nack_next)
                                begin
                                    sda_pull  <= 1'b1;
                                    addr[7:0] <= shreg;
                                end
                            end
                            2'd2:
                            begin
                                wdata      <= shreg;
                                wr_pending <= 1'b1;
                                sda_pull   <= 1'b1;
                            end
                            default:
                            begin
                                sda_pull <= 1'b0;  // no page writes
                            end
                        endcase
                        if (byte_idx != 2'd3)
                            byte_idx <= byte_idx + 2'd1;
                    end
                end
                else if (cnt == 4'd9)
                begin
                    cnt <= 4'd0;
                    if (tx)
                    begin
                        tx       <= 1'b0;
                        sda_pull <= 1'b0;
                    end
                    else if (tx_next && sda_pull)
                    begin
                        tx       <= 1'b1;
                        tx_next  <= 1'b0;
                        txbyte   <= mem[addr];
                        sda_pull <= ~mem[addr][7];
                    end
                    else
                        sda_pull <= 1'b0;
                end
                else if (tx && cnt >= 4'd1 && cnt <= 4'd7)
                    sda_pull <= ~txbyte[3'(7 - cnt)];
            end
        end
    end

endmodule

// ==== tests/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    // worst case read plus idle gap and margin
    localparam int REQ_CYCLES = 4 * eeprom_pkg::CLKS_PER_QUARTER * (3 + 4 * 9) + 176;
    localparam int NUM_REQ    = 200;
    localparam int TIMEOUT    = NUM_REQ * REQ_CYCLES + 10;

    logic                          CLK;
    logic                          RESET;
    logic                          req_valid;
    logic                          req_write;
    logic [eeprom_pkg::ADDR_W-1:0] req_addr;
    logic [eeprom_pkg::DATA_W-1:0] req_wdata;
    logic                          req_ready;
    logic                          rsp_valid;
    logic [eeprom_pkg::DATA_W-1:0] rsp_rdata;
    logic                          rsp_nack;
    logic                          scl;
    logic                          sda_pull;
    logic                          slave_pull;
    logic                          sda;
    logic                          nack_next;
    logic                          bus_error;

    logic [eeprom_pkg::DATA_W-1:0] ref_mem [0:2047];
    int                            cycles;
    int                            accepted;
    int                            rsp_count;

    assign sda = !(sda_pull || slave_pull);   // wired-AND

    eeprom_ctrl_top u_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda)
    );

    eeprom_model u_model (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda),
        .nack_next (nack_next),
        .sda_pull  (slave_pull),
        .bus_error (bus_error)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: the run hung, no progress after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(posedge CLK)
    begin
        if (!RESET)
            check_value("bus_error", 32'(bus_error), 32'd0);
        if (rsp_valid)
            rsp_count <= rsp_count + 1;
    end

    // one request from idle gap to response
    task automatic run_request(input logic wr, input logic [10:0] a, input logic [7:0] d,
                               input logic nk, input int gap);
        repeat (gap) @(posedge CLK);
        @(posedge CLK);
        #1;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = a;
        req_wdata = d;
        nack_next = nk;
        do
            @(negedge CLK);
        while (!req_ready);
        @(posedge CLK);
        #1;
        accepted++;
        // a different request stays pending while busy
        req_write = !wr;
        req_addr  = ~a;
        req_wdata = ~d;
        forever
        begin
            @(negedge CLK);
            if (rsp_valid)
                break;
            check_value("req_ready", 32'(req_ready), 32'd0);
        end
        check_value("rsp_nack", 32'(rsp_nack), 32'(nk));
        if (!wr && !nk)
            check_value("rsp_rdata", 32'(rsp_rdata), 32'(ref_mem[a]));
        if (wr && !nk)
            ref_mem[a] = d;
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
        nack_next = 1'b0;
        @(negedge CLK);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        check_value("req_ready", 32'(req_ready), 32'd1);
    endtask

    initial
    begin
        logic [10:0] a;
        logic [7:0]  d;
        void'($urandom(32'hb164));
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'(i * 7) ^ 8'(i >> 8);
        cycles = 0;
        accepted = 0;
        rsp_count = 0;
        RESET = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        nack_next = 1'b0;
        repeat (10) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_pull", 32'(sda_pull), 32'd0);
        check_value("req_ready", 32'(req_ready), 32'd1);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);

        // write, a nacked write that must not land, then read back
        run_request(1'b1, 11'h5a3, 8'h3c, 1'b0, 0);
        run_request(1'b1, 11'h5a3, 8'hc5, 1'b1, 1);
        run_request(1'b0, 11'h5a3, 8'h00, 1'b0, 0);

        for (int n = 3; n < NUM_REQ; n++)
        begin
            a = 11'($urandom);
            d = 8'($urandom);
            run_request(1'($urandom), a, d, ($urandom % 8) == 0, int'($urandom % 6));
        end

        @(negedge CLK);
        check_value("rsp_count", 32'(rsp_count), 32'(accepted));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
hw/eeprom_pkg.sv
hw/i2c_byte_if.sv
hw/i2c_bit_engine.sv
hw/eeprom_sequencer.sv
hw/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/tb_eeprom_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_eeprom_ctrl
FILELIST  = src.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -E '\.s?v$$' $(FILELIST))
LOG       = sim.log

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
